// ==== verilog/video_pkg.sv ====
// raster types shared by the timing generator, the renderer and the top level
// import inside a module body, or use scoped names in port lists
package video_pkg;

    // screen coordinate width, enough for up to 1023
    localparam int CORDW = 10;

    // current raster position
    typedef struct packed {
        logic [CORDW-1:0] sx;  // horizontal, 0 at first active pixel
        logic [CORDW-1:0] sy;  // vertical, 0 at first active line
    } scan_pos_t;

    // sync group, both syncs active low
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;     // data enable, high in active area
    } vid_sync_t;

    // 12-bit colour, rgb 4:4:4
    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } pixel_t;

endpackage : video_pkg

// ==== verilog/pong_pkg.sv ====
// game objects, configuration, APB bus and register map for the pong core
// coordinate and colour widths come from video_pkg
package pong_pkg;

    // top-left corner of a screen object
    typedef struct packed {
        logic [video_pkg::CORDW-1:0] x;
        logic [video_pkg::CORDW-1:0] y;
    } obj_pos_t;

    // host-controlled game settings
    typedef struct packed {
        logic              run;        // 1 lets objects move
        logic [3:0]        ball_spx;   // pixels per frame, x
        logic [3:0]        ball_spy;   // pixels per frame, y
        logic [3:0]        pad_speed;  // both paddles
        video_pkg::pixel_t fg_color;   // ball and paddle colour
    } game_cfg_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [7:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // register offsets
    typedef enum logic [7:0] {
        REG_CTRL  = 8'h00,  // bit 0 run
        REG_SPEED = 8'h04,  // spx 3:0, spy 7:4, pad 11:8
        REG_COLOR = 8'h08,  // rgb 11:0
        REG_BALL  = 8'h0C,  // ro, x 9:0, y 25:16
        REG_FRAME = 8'h10   // ro, frame tick count
    } reg_addr_e;

endpackage : pong_pkg

// ==== verilog/display_timings.sv ====
// raster timing generator, scan position plus syncs and data enable
// frame_tick pulses once at the start of vertical blanking
`timescale 1ns/100ps

module display_timings #(
    parameter int H_RES  = 640,  // active pixels per line
    parameter int H_FP   = 16,
    parameter int H_SYNC = 96,
    parameter int H_BP   = 48,
    parameter int V_RES  = 480,  // active lines per frame
    parameter int V_FP   = 10,
    parameter int V_SYNC = 2,
    parameter int V_BP   = 33
) (
    input  logic                 clk_pix,
    input  logic                 rst_n,
    output video_pkg::scan_pos_t pos,
    output video_pkg::vid_sync_t sync,
    output logic                 frame_tick
);
    import video_pkg::*;

    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;
    localparam int HS_STA  = H_RES + H_FP;   // sync follows front porch
    localparam int HS_END  = HS_STA + H_SYNC;
    localparam int VS_STA  = V_RES + V_FP;
    localparam int VS_END  = VS_STA + V_SYNC;

    logic h_last;  // last pixel of the line
    logic v_last;  // last line of the frame

    always_comb begin
        h_last = (pos.sx == CORDW'(H_TOTAL - 1));
        v_last = (pos.sy == CORDW'(V_TOTAL - 1));
    end

    // wrapping counters
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            pos <= '0;  // first position is 0,0
        end else if (h_last) begin
            pos.sx <= '0;
            pos.sy <= v_last ? '0 : pos.sy + 1'b1;
        end else begin
            pos.sx <= pos.sx + 1'b1;
        end
    end

    always_comb begin
        sync.hsync = !((pos.sx >= CORDW'(HS_STA)) && (pos.sx < CORDW'(HS_END)));  // active low
        sync.vsync = !((pos.sy >= CORDW'(VS_STA)) && (pos.sy < CORDW'(VS_END)));
        sync.de    = (pos.sx < CORDW'(H_RES)) && (pos.sy < CORDW'(V_RES));
        frame_tick = (pos.sy == CORDW'(V_RES)) && (pos.sx == '0);  // start of vblank
    end

endmodule : display_timings

// ==== verilog/pong_regs.sv ====
// APB slave for game configuration and status readback, no wait states
// writes land at the end of the access cycle, reads are combinational
`timescale 1ns/100ps

module pong_regs (
    input  logic                clk_pix,
    input  logic                rst_n,
    input  pong_pkg::apb_req_t  apb_req,
    output pong_pkg::apb_rsp_t  apb_rsp,
    input  logic                frame_tick,
    input  pong_pkg::obj_pos_t  ball,
    output pong_pkg::game_cfg_t cfg
);
    import pong_pkg::*;

    logic        access;     // access phase of a transfer
    logic        wr_ok;      // accepted write
    logic        bad_acc;    // unmapped or read-only write
    logic [31:0] rd_data;
    logic [15:0] frame_cnt;  // free running

    always_comb begin
        access  = apb_req.psel && apb_req.penable;
        rd_data = '0;
        bad_acc = 1'b0;
        case (apb_req.paddr)
            REG_CTRL:  rd_data = {31'd0, cfg.run};
            REG_SPEED: rd_data = {20'd0, cfg.pad_speed, cfg.ball_spy, cfg.ball_spx};
            REG_COLOR: rd_data = {20'd0, cfg.fg_color};
            REG_BALL: begin
                rd_data = {6'd0, ball.y, 6'd0, ball.x};
                bad_acc = apb_req.pwrite;  // read only
            end
            REG_FRAME: begin
                rd_data = {16'd0, frame_cnt};
                bad_acc = apb_req.pwrite;  // read only
            end
            default:   bad_acc = 1'b1;     // unmapped
        endcase
        wr_ok = access && apb_req.pwrite && !bad_acc;
    end

    always_comb begin
        apb_rsp.prdata  = access ? rd_data : '0;  // quiet outside access
        apb_rsp.pready  = 1'b1;                   // never stalls
        apb_rsp.pslverr = access && bad_acc;
    end

    // writable fields
    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            cfg.run       <= 1'b0;     // game stopped
            cfg.ball_spx  <= 4'd1;
            cfg.ball_spy  <= 4'd1;
            cfg.pad_speed <= 4'd1;
            cfg.fg_color  <= 12'hFFF;  // white
        end else if (wr_ok) begin
            case (apb_req.paddr)
                REG_CTRL:  cfg.run <= apb_req.pwdata[0];
                REG_SPEED: begin
                    cfg.ball_spx  <= apb_req.pwdata[3:0];
                    cfg.ball_spy  <= apb_req.pwdata[7:4];
                    cfg.pad_speed <= apb_req.pwdata[11:8];
                end
                REG_COLOR: cfg.fg_color <= apb_req.pwdata[11:0];
                default:   ;  // nothing else writable
            endcase
        end
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n)          frame_cnt <= '0;
        else if (frame_tick) frame_cnt <= frame_cnt + 1'b1;  // wraps at 16 bits
    end

endmodule : pong_regs

// ==== verilog/paddle_ai.sv ====
// self-steering paddle, follows the ball one step per frame tick
// the same block serves both sides
`timescale 1ns/100ps

module paddle_ai #(
    parameter int V_RES    = 480,
    parameter int P_HEIGHT = 40,
    parameter int B_SIZE   = 8
) (
    input  logic                        clk_pix,
    input  logic                        rst_n,
    input  logic                        frame_tick,
    input  logic                        run,
    input  logic [3:0]                  speed,
    input  logic [video_pkg::CORDW-1:0] ball_y,
    output logic [video_pkg::CORDW-1:0] pad_y
);
    import video_pkg::*;

    typedef enum logic [1:0] {MV_HOLD, MV_UP, MV_DOWN} move_e;

    move_e            move;
    logic [CORDW-1:0] spd;     // speed at coordinate width
    logic [CORDW-1:0] centre;  // paddle midpoint

    always_comb begin
        spd    = CORDW'(speed);
        centre = pad_y + CORDW'(P_HEIGHT / 2);
        move   = MV_HOLD;
        if (centre < ball_y) begin                      // ball top below centre
            if (pad_y < CORDW'(V_RES - P_HEIGHT) - spd) move = MV_DOWN;  // room below
        end else if (centre > ball_y + CORDW'(B_SIZE)) begin  // ball bottom above
            if (pad_y > spd) move = MV_UP;              // room above
        end
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            pad_y <= CORDW'((V_RES - P_HEIGHT) / 2);  // vertically centred
        end else if (frame_tick && run) begin
            case (move)
                MV_DOWN: pad_y <= pad_y + spd;
                MV_UP:   pad_y <= pad_y - spd;
                default: pad_y <= pad_y;
            endcase
        end
    end

endmodule : paddle_ai

// ==== verilog/ball_motion.sv ====
// ball position update, once per frame tick while running
// each axis bounces off its two screen edges on its own
`timescale 1ns/100ps

module ball_motion #(
    parameter int H_RES  = 640,
    parameter int V_RES  = 480,
    parameter int B_SIZE = 8
) (
    input  logic               clk_pix,
    input  logic               rst_n,
    input  logic               frame_tick,
    input  logic               run,
    input  logic [3:0]         spx,
    input  logic [3:0]         spy,
    output pong_pkg::obj_pos_t ball
);
    import video_pkg::*;

    logic             dx;    // 0 right, 1 left
    logic             dy;    // 0 down, 1 up
    logic [CORDW-1:0] sx_w;  // speeds at coordinate width
    logic [CORDW-1:0] sy_w;
    logic [CORDW-1:0] x_hi;  // right edge turn point
    logic [CORDW-1:0] y_hi;  // bottom edge turn point
    logic             step;

    always_comb begin
        sx_w = CORDW'(spx);
        sy_w = CORDW'(spy);
        x_hi = CORDW'(H_RES - B_SIZE) - sx_w;
        y_hi = CORDW'(V_RES - B_SIZE) - sy_w;
        step = frame_tick && run;
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            ball.x <= CORDW'(H_RES / 2);  // centre of screen
            ball.y <= CORDW'(V_RES / 2);
            dx     <= 1'b0;
            dy     <= 1'b0;
        end else if (step) begin
            if (ball.x >= x_hi) begin         // right edge
                dx     <= 1'b1;
                ball.x <= ball.x - sx_w;
            end else if (ball.x < sx_w) begin // left edge
                dx     <= 1'b0;
                ball.x <= ball.x + sx_w;
            end else begin
                ball.x <= dx ? ball.x - sx_w : ball.x + sx_w;
            end

            if (ball.y >= y_hi) begin         // bottom edge
                dy     <= 1'b1;
                ball.y <= ball.y - sy_w;
            end else if (ball.y < sy_w) begin // top edge
                dy     <= 1'b0;
                ball.y <= ball.y + sy_w;
            end else begin
                ball.y <= dy ? ball.y - sy_w : ball.y + sy_w;
            end
        end
    end

endmodule : ball_motion

// ==== verilog/pong_render.sv ====
// pixel renderer, rectangle hit tests for ball and paddles
// output pixel and syncs are registered together, one cycle latency
`timescale 1ns/100ps

module pong_render #(
    parameter int H_RES    = 640,
    parameter int P_HEIGHT = 40,
    parameter int P_WIDTH  = 10,
    parameter int P_OFFSET = 32,
    parameter int B_SIZE   = 8
) (
    input  logic                        clk_pix,
    input  logic                        rst_n,
    input  video_pkg::scan_pos_t        pos,
    input  video_pkg::vid_sync_t        sync_in,
    input  pong_pkg::obj_pos_t          ball,
    input  logic [video_pkg::CORDW-1:0] pad1_y,
    input  logic [video_pkg::CORDW-1:0] pad2_y,
    input  video_pkg::pixel_t           color,
    output video_pkg::pixel_t           pixel,
    output video_pkg::vid_sync_t        sync_out
);
    import video_pkg::*;

    logic p1_hit, p2_hit, b_hit;

    always_comb begin
        p1_hit = (pos.sx >= CORDW'(P_OFFSET)) && (pos.sx < CORDW'(P_OFFSET + P_WIDTH))
              && (pos.sy >= pad1_y) && (pos.sy < pad1_y + CORDW'(P_HEIGHT));
        p2_hit = (pos.sx >= CORDW'(H_RES - P_OFFSET - P_WIDTH))
              && (pos.sx < CORDW'(H_RES - P_OFFSET))
              && (pos.sy >= pad2_y) && (pos.sy < pad2_y + CORDW'(P_HEIGHT));
        b_hit  = (pos.sx >= ball.x) && (pos.sx < ball.x + CORDW'(B_SIZE))
              && (pos.sy >= ball.y) && (pos.sy < ball.y + CORDW'(B_SIZE));
    end

    always_ff @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) begin
            pixel    <= '0;
            sync_out <= '{hsync: 1'b1, vsync: 1'b1, de: 1'b0};  // syncs idle high
        end else begin
            pixel    <= (sync_in.de && (p1_hit || p2_hit || b_hit)) ? color : '0;  // black in blanking
            sync_out <= sync_in;  // keep aligned with pixel
        end
    end

endmodule : pong_render

// ==== verilog/pong_top.sv ====
// pong display core, raster timing, game logic, renderer and APB registers
// screen and object geometry are set here and passed down
`timescale 1ns/100ps

module pong_top #(
    parameter int H_RES    = 640,
    parameter int H_FP     = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BP     = 48,
    parameter int V_RES    = 480,
    parameter int V_FP     = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BP     = 33,
    parameter int P_HEIGHT = 40,   // paddle size in pixels
    parameter int P_WIDTH  = 10,
    parameter int P_OFFSET = 32,   // paddle gap from screen edge
    parameter int B_SIZE   = 8     // ball side in pixels
) (
    input  logic                 clk_pix,
    input  logic                 rst_n,
    input  pong_pkg::apb_req_t   apb_req,
    output pong_pkg::apb_rsp_t   apb_rsp,
    output video_pkg::pixel_t    pixel,
    output video_pkg::vid_sync_t sync
);
    import video_pkg::*;
    import pong_pkg::*;

    scan_pos_t        pos;
    vid_sync_t        raw_sync;    // undelayed syncs from the counters
    logic             frame_tick;
    game_cfg_t        cfg;
    obj_pos_t         ball;
    logic [CORDW-1:0] pad1_y, pad2_y;

    display_timings #(
        .H_RES(H_RES), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_RES(V_RES), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) i_timings (
        .clk_pix, .rst_n, .pos, .sync(raw_sync), .frame_tick
    );

    pong_regs i_regs (
        .clk_pix, .rst_n, .apb_req, .apb_rsp, .frame_tick, .ball, .cfg
    );

    ball_motion #(.H_RES(H_RES), .V_RES(V_RES), .B_SIZE(B_SIZE)) i_ball (
        .clk_pix, .rst_n, .frame_tick, .run(cfg.run),
        .spx(cfg.ball_spx), .spy(cfg.ball_spy), .ball
    );

    paddle_ai #(.V_RES(V_RES), .P_HEIGHT(P_HEIGHT), .B_SIZE(B_SIZE)) i_pad1 (
        .clk_pix, .rst_n, .frame_tick, .run(cfg.run), .speed(cfg.pad_speed),
        .ball_y(ball.y), .pad_y(pad1_y)
    );

    paddle_ai #(.V_RES(V_RES), .P_HEIGHT(P_HEIGHT), .B_SIZE(B_SIZE)) i_pad2 (
        .clk_pix, .rst_n, .frame_tick, .run(cfg.run), .speed(cfg.pad_speed),
        .ball_y(ball.y), .pad_y(pad2_y)
    );

    pong_render #(
        .H_RES(H_RES), .P_HEIGHT(P_HEIGHT), .P_WIDTH(P_WIDTH),
        .P_OFFSET(P_OFFSET), .B_SIZE(B_SIZE)
    ) i_render (
        .clk_pix, .rst_n, .pos, .sync_in(raw_sync), .ball, .pad1_y, .pad2_y,
        .color(cfg.fg_color), .pixel, .sync_out(sync)
    );

endmodule : pong_top

// ==== bench/pong_assert.sv ====
// concurrent checks on the APB response and the video sync group
// attached to every pong_top instance by the bind at the bottom
`timescale 1ns/100ps

module pong_assert (
    input logic                 clk_pix,
    input logic                 rst_n,
    input pong_pkg::apb_req_t   apb_req,
    input pong_pkg::apb_rsp_t   apb_rsp,
    input video_pkg::vid_sync_t sync
);

    int fail_cnt = 0;  // assertion failures so far

    // zero wait states so ready never drops
    a_pready_high: assert property (@(posedge clk_pix) disable iff (!rst_n)
        apb_rsp.pready)
        else begin
            $error("apb pready went low");
            fail_cnt++;
        end

    // error response belongs to the access phase only
    a_slverr_access: assert property (@(posedge clk_pix) disable iff (!rst_n)
        apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable))
        else begin
            $error("apb pslverr outside access phase");
            fail_cnt++;
        end

    // active video never overlaps a sync pulse
    a_de_no_sync: assert property (@(posedge clk_pix) disable iff (!rst_n)
        sync.de |-> (sync.hsync && sync.vsync))
        else begin
            $error("de high during a sync pulse");
            fail_cnt++;
        end

endmodule : pong_assert

bind pong_top pong_assert i_assert (
    .clk_pix, .rst_n, .apb_req, .apb_rsp, .sync
);

// ==== bench/pong_checker.sv ====
// watches the pong_top outputs and holds a frame-level model of the game
// compares every pixel and sync, and the APB responses the bench reports
`timescale 1ns/100ps

module pong_checker #(
    parameter int H_RES = 640, H_FP = 16, H_SYNC = 96, H_BP = 48,
    parameter int V_RES = 480, V_FP = 10, V_SYNC = 2, V_BP = 33,
    parameter int P_HEIGHT = 40, P_WIDTH = 10, P_OFFSET = 32, B_SIZE = 8
) (
    input logic                 clk_pix,
    input logic                 rst_n,
    input video_pkg::pixel_t    pixel,
    input video_pkg::vid_sync_t sync
);
    import video_pkg::*;
    import pong_pkg::*;

    localparam int H_TOT = H_RES + H_FP + H_SYNC + H_BP;
    localparam int V_TOT = V_RES + V_FP + V_SYNC + V_BP;

    typedef struct packed {
        int x;
        int y;
        bit dx;   // 1 left
        bit dy;   // 1 up
        int pad;  // both paddles follow the same ball
    } model_t;

    model_t      m = '{x: H_RES / 2, y: V_RES / 2, dx: 1'b0, dy: 1'b0,
                       pad: (V_RES - P_HEIGHT) / 2};
    int          cyc;         // rising edges since reset release
    int          ticks = 0;   // frame ticks seen
    int          err_cnt = 0;
    bit          run = 1'b0;
    int          spx = 1, spy = 1, psp = 1;
    pixel_t      col = 12'hFFF;
    bit          pend = 1'b0;  // accepted write not yet landed
    int          pend_idx;
    logic [7:0]  pend_addr;
    logic [31:0] pend_data;

    // one frame of motion with per axis bounce then paddle chase
    function automatic model_t next_frame(input model_t s, input int vx, input int vy,
                                          input int vp);
        model_t n;
        n = s;
        if (s.x >= H_RES - (vx + B_SIZE)) begin
            n.dx = 1'b1;
            n.x  = s.x - vx;
        end else if (s.x < vx) begin
            n.dx = 1'b0;
            n.x  = s.x + vx;
        end else n.x = s.dx ? s.x - vx : s.x + vx;
        if (s.y >= V_RES - (vy + B_SIZE)) begin
            n.dy = 1'b1;
            n.y  = s.y - vy;
        end else if (s.y < vy) begin
            n.dy = 1'b0;
            n.y  = s.y + vy;
        end else n.y = s.dy ? s.y - vy : s.y + vy;
        if (s.pad + P_HEIGHT / 2 < s.y) begin     // ball below centre
            if (s.pad < V_RES - (P_HEIGHT + vp)) n.pad = s.pad + vp;
        end else if (s.pad + P_HEIGHT / 2 > s.y + B_SIZE) begin
            if (s.pad > vp) n.pad = s.pad - vp;
        end
        return n;
    endfunction

    function automatic bit covered(input int x, input int y);
        bit p1, p2, b;
        p1 = x >= P_OFFSET && x < P_OFFSET + P_WIDTH && y >= m.pad && y < m.pad + P_HEIGHT;
        p2 = x >= H_RES - P_OFFSET - P_WIDTH && x < H_RES - P_OFFSET
             && y >= m.pad && y < m.pad + P_HEIGHT;
        b  = x >= m.x && x < m.x + B_SIZE && y >= m.y && y < m.y + B_SIZE;
        return p1 || p2 || b;
    endfunction

    function automatic logic [31:0] read_value(input logic [7:0] addr);
        case (addr)
            REG_CTRL:  return {31'd0, run};
            REG_SPEED: return {20'd0, 4'(psp), 4'(spy), 4'(spx)};
            REG_COLOR: return {20'd0, col};
            REG_BALL:  return {6'd0, 10'(m.y), 6'd0, 10'(m.x)};
            REG_FRAME: return {16'd0, 16'(ticks)};
            default:   return 32'd0;
        endcase
    endfunction

    // called by the bench while the access phase is on the bus
    task automatic note_access(input bit wr, input logic [7:0] addr, input logic [31:0] data,
                               input logic err);
        bit          exp_err;
        logic [31:0] exp_d;
        exp_err = !(addr inside {REG_CTRL, REG_SPEED, REG_COLOR, REG_BALL, REG_FRAME})
                  || (wr && (addr == REG_BALL || addr == REG_FRAME));
        exp_d   = read_value(addr);
        if (err !== exp_err) begin
            err_cnt++;
            $display("[ERROR] %0t apb addr %h pslverr expected %b got %b", $time, addr,
                     exp_err, err);
        end
        if (!wr && data !== exp_d) begin
            err_cnt++;
            $display("[ERROR] %0t apb read %h expected %h got %h", $time, addr, exp_d, data);
        end
        if (wr && !exp_err) begin
            pend      = 1'b1;
            pend_idx  = cyc + 1;  // lands on the next edge
            pend_addr = addr;
            pend_data = data;
        end
    endtask

    always @(posedge clk_pix or negedge rst_n) begin
        if (!rst_n) cyc <= 0;
        else        cyc <= cyc + 1;
    end

    always @(negedge clk_pix) begin
        int     p, sx, sy;
        pixel_t exp_pix;
        vid_sync_t exp_sync;
        if (!rst_n) begin
            exp_sync = '{hsync: 1'b1, vsync: 1'b1, de: 1'b0};
            exp_pix  = '0;
        end
        if (rst_n && cyc >= 1) begin
            p = cyc - 1;  // raster index shown on the outputs now
            if (pend && pend_idx <= p) begin
                pend = 1'b0;
                case (pend_addr)
                    REG_CTRL:  run = pend_data[0];
                    REG_SPEED: {psp, spy, spx} = {28'd0, pend_data[11:8], 28'd0,
                                                  pend_data[7:4], 28'd0, pend_data[3:0]};
                    default:   col = pend_data[11:0];
                endcase
            end
            sx = p % H_TOT;
            sy = (p / H_TOT) % V_TOT;
            exp_sync.hsync = !(sx >= H_RES + H_FP && sx < H_RES + H_FP + H_SYNC);
            exp_sync.vsync = !(sy >= V_RES + V_FP && sy < V_RES + V_FP + V_SYNC);
            exp_sync.de    = sx < H_RES && sy < V_RES;
            exp_pix        = (exp_sync.de && covered(sx, sy)) ? col : '0;
            if (sx == 0 && sy == V_RES) begin  // frame tick at the start of vblank
                ticks++;
                if (run) m = next_frame(m, spx, spy, psp);
            end
        end
        if (!rst_n || cyc >= 1) begin
            if (pixel !== exp_pix || sync !== exp_sync) begin
                err_cnt++;
                $display("[ERROR] %0t pixel/sync expected %h/%b got %h/%b", $time,
                         exp_pix, exp_sync, pixel, sync);
            end
        end
    end

endmodule : pong_checker

// ==== bench/tb_pong.sv ====
// top-level testbench for pong_top on a shrunken 64x48 screen
// drives APB traffic while the checker compares video and register reads
`timescale 1ns/100ps

module tb_pong;
    import video_pkg::*;
    import pong_pkg::*;

    localparam int FRAME_CYC    = 4400;
    localparam int TOTAL_FRAMES = 2 + 1 + 30 + 24;  // idle, regs, ball and paddle tests
    localparam int LIMIT        = (TOTAL_FRAMES + 4) * FRAME_CYC;

    logic        clk_pix = 1'b0;
    logic        rst_n = 1'b0;
    apb_req_t    apb_req = '0;
    apb_rsp_t    apb_rsp;
    pixel_t      pixel;
    vid_sync_t   sync;
    logic [15:0] lfsr = 16'd97;
    int          cycles = 0;
    int          n_tests = 0;
    int          n_failed = 0;

    pong_top #(.H_RES(64), .H_FP(4), .H_SYNC(6), .H_BP(6), .V_RES(48), .V_FP(2), .V_SYNC(2),
               .V_BP(3), .P_HEIGHT(12), .P_WIDTH(3), .P_OFFSET(4), .B_SIZE(4)) i_dut (
        .clk_pix, .rst_n, .apb_req, .apb_rsp, .pixel, .sync
    );

    pong_checker #(.H_RES(64), .H_FP(4), .H_SYNC(6), .H_BP(6), .V_RES(48), .V_FP(2),
                   .V_SYNC(2), .V_BP(3), .P_HEIGHT(12), .P_WIDTH(3), .P_OFFSET(4),
                   .B_SIZE(4)) i_chk (.clk_pix, .rst_n, .pixel, .sync);

    initial begin
        forever #20 clk_pix = ~clk_pix;  // 40 ns period
    end

    always @(posedge clk_pix) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: test sequence still running after %0d cycles", LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    // fibonacci with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [11:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[10:0], lfsr[0]};
        end
    endtask

    // checker mismatches plus bound assertion failures
    function automatic int total_errors();
        return i_chk.err_cnt + i_dut.i_assert.fail_cnt;
    endfunction

    // one transfer entered and left 2 ns after a rising edge
    task automatic apb_xfer(input bit wr, input logic [7:0] addr, input logic [31:0] wdata);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(posedge clk_pix);
        #2 apb_req.penable = 1'b1;
        #20 i_chk.note_access(wr, addr, wr ? wdata : apb_rsp.prdata, apb_rsp.pslverr);
        @(posedge clk_pix);
        #2 apb_req = '0;
    endtask

    task automatic wait_frames(input int n);
        int target;
        target = i_chk.ticks + n;
        while (i_chk.ticks < target) @(posedge clk_pix);
        #2;
    endtask

    task automatic report_test(input string name, input int err_before);
        int errs;
        errs = total_errors() - err_before;
        n_tests++;
        if (errs != 0) n_failed++;
        $display("test %s: %s, %0d errors", name, errs == 0 ? "ok" : "bad", errs);
    endtask

    initial begin
        int          e0;
        logic [11:0] r;
        logic [11:0] r2;
        int          pads[6] = '{1, 5, 15, 9, 12, 3};
        repeat (10) @(posedge clk_pix);
        #2 rst_n = 1'b1;

        e0 = total_errors();  // reset and idle
        wait_frames(2);
        apb_xfer(0, REG_BALL, 0);
        apb_xfer(0, REG_FRAME, 0);
        report_test("reset_idle", e0);

        e0 = total_errors();  // register access
        apb_xfer(1, REG_SPEED, 32'h0000_0321);
        apb_xfer(0, REG_SPEED, 0);
        apb_xfer(1, REG_COLOR, 32'h0000_0A5C);
        apb_xfer(0, REG_COLOR, 0);
        apb_xfer(1, REG_CTRL, 32'h1);
        apb_xfer(0, REG_CTRL, 0);
        apb_xfer(1, REG_CTRL, 32'h0);
        apb_xfer(0, REG_CTRL, 0);
        apb_xfer(0, 8'h14, 0);            // unmapped read
        apb_xfer(1, 8'h14, 32'hFFFF);     // unmapped write
        apb_xfer(1, REG_BALL, 32'h0);     // read only
        apb_xfer(0, REG_BALL, 0);
        apb_xfer(0, REG_SPEED, 0);
        report_test("register_access", e0);

        e0 = total_errors();  // ball motion with random speeds
        apb_xfer(1, REG_CTRL, 32'h1);
        for (int i = 0; i < 10; i++) begin
            take_bits(3, r);
            take_bits(3, r2);
            if (r == 0) r = 1;
            if (r2 == 0) r2 = 1;
            apb_xfer(1, REG_SPEED, {20'd0, 4'd1, r2[3:0], r[3:0]});
            wait_frames(3);
            apb_xfer(0, REG_BALL, 0);
        end
        report_test("ball_motion", e0);

        e0 = total_errors();  // paddle tracking with mid-frame colour writes
        foreach (pads[i]) begin
            take_bits(3, r);
            if (r == 0) r = 1;
            apb_xfer(1, REG_SPEED, {20'd0, 4'(pads[i]), r[3:0], 4'd7});
            wait_frames(2);
            repeat (20 * 80) @(posedge clk_pix);  // middle of the active area
            #2;
            take_bits(12, r2);
            apb_xfer(1, REG_COLOR, {20'd0, r2 | 12'h111});
            wait_frames(2);
            apb_xfer(0, REG_BALL, 0);
        end
        report_test("paddle_render", e0);

        $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, total_errors());
        if (total_errors() == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : tb_pong

// ==== compile.f ====
verilog/video_pkg.sv
verilog/pong_pkg.sv
verilog/display_timings.sv
verilog/pong_regs.sv
verilog/paddle_ai.sv
verilog/ball_motion.sv
verilog/pong_render.sv
verilog/pong_top.sv
bench/pong_assert.sv
bench/pong_checker.sv
bench/tb_pong.sv

// ==== Makefile ====
# Verilator build and run of the pong testbench
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_pong
FLIST = compile.f
LOG   = sim.log

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
